// File: include/mmio_cfg.svh
`ifndef MMIO_CFG_SVH
`define MMIO_CFG_SVH

// ==============================
// bus widths
// ==============================

// core address width
`define MMIO_XLEN 64
// read and write data width
`define MMIO_DATA_W 64
// one enable bit per data byte
`define MMIO_MASK_W 8

// ==============================
// memory map
// ==============================

// boot rom window
`define MMIO_ROM_BEGIN 64'h0000_0000_0000_1000
`define MMIO_ROM_END 64'h0000_0000_0000_1fff

// aclint timer and soft irq block
`define MMIO_ACLINT_BEGIN 64'h0000_0000_0200_0000
`define MMIO_ACLINT_END 64'h0000_0000_020b_ffff

// ram base, open ended upward
`define MMIO_RAM_BEGIN 64'h0000_0000_8000_0000

// debug window length in bytes, base comes from dbg_addr
`define MMIO_DBG_SIZE 8

`endif

// File: hw/mmio_pkg.sv
`include "mmio_cfg.svh"

package mmio_pkg;

    // ==============================
    // bus vector types
    // ==============================

    // full bus address, also used for window offsets
    typedef logic [`MMIO_XLEN-1:0] addr_t;

    // one read or write data word
    typedef logic [`MMIO_DATA_W-1:0] data_t;

    // byte write enables
    typedef logic [`MMIO_MASK_W-1:0] mask_t;

    // ==============================
    // decoded targets
    // ==============================

    // unmapped is zero so an idle slot reads as no target
    typedef enum logic [2:0] {
        target_unmapped,
        target_ram,
        target_rom,
        target_dbg,
        target_aclint
    } mmio_target_t;

endpackage

// File: hw/mmio_decoder.sv
`include "mmio_cfg.svh"

module mmio_decoder import mmio_pkg::*; (
    // full core address
    input  addr_t        addr,
    // run-time base of the debug window
    input  addr_t        dbg_addr,
    output mmio_target_t target,
    // address relative to the matching window base
    output addr_t        offset
);

    // distance from the debug base, only meaningful when addr >= dbg_addr
    addr_t dbg_rel;

    // per-window hits, before priority
    logic dbg_hit;
    logic rom_hit;
    logic aclint_hit;
    logic ram_hit;

    assign dbg_rel = addr - dbg_addr;

    // lower bound checked first so the subtraction cannot wrap into the window
    assign dbg_hit = (addr >= dbg_addr) && (dbg_rel < addr_t'(`MMIO_DBG_SIZE));

    assign rom_hit = (addr >= `MMIO_ROM_BEGIN) && (addr <= `MMIO_ROM_END);

    assign aclint_hit = (addr >= `MMIO_ACLINT_BEGIN) && (addr <= `MMIO_ACLINT_END);

    // everything from the ram base upward
    assign ram_hit = (addr >= `MMIO_RAM_BEGIN);

    // ==============================
    // priority select
    // ==============================
    always_comb begin
        target = target_unmapped;
        offset = '0;
        // debug window wins, it may sit inside ram space
        if (dbg_hit) begin
            target = target_dbg;
            offset = dbg_rel;
        end else if (rom_hit) begin
            target = target_rom;
            offset = addr - `MMIO_ROM_BEGIN;
        end else if (aclint_hit) begin
            target = target_aclint;
            offset = addr - `MMIO_ACLINT_BEGIN;
        end else if (ram_hit) begin
            target = target_ram;
            offset = addr - `MMIO_RAM_BEGIN;
        end
        // no window hit, stays unmapped with zero offset
    end

endmodule

// File: hw/mmio_request_slot.sv
`include "mmio_cfg.svh"

module mmio_request_slot import mmio_pkg::*; (
    input  logic         clk,
    input  logic         rst,

    // core request strobes
    input  logic         core_valid,
    input  logic         core_wen,
    input  data_t        core_wdata,
    input  mask_t        core_wmask,

    // decode of the current core address
    input  mmio_target_t dec_target,
    input  addr_t        dec_offset,

    // completion from the selected target
    input  logic         rsp_valid,

    output logic         core_ready,

    // held request
    output logic         slot_valid,
    output mmio_target_t slot_target,
    output addr_t        slot_offset,
    output logic         slot_wen,
    output data_t        slot_wdata,
    output mask_t        slot_wmask
);

    // request taken this edge
    logic accept;

    // ready only while nothing is outstanding
    assign core_ready = !slot_valid;

    assign accept = core_valid && core_ready;

    // ==============================
    // slot state
    // ==============================
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            slot_valid  <= 1'b0;
            slot_target <= target_unmapped;
        end else begin
            if (slot_valid) begin
                // rsp_valid already qualified by slot_valid in the mux
                if (rsp_valid) begin
                    slot_valid <= 1'b0;
                end
            end else if (accept) begin
                slot_valid  <= 1'b1;
                slot_target <= dec_target;
            end
        end
    end

    // ==============================
    // payload capture
    // ==============================

    // payload latched on acceptance
    always_ff @(posedge clk) begin
        if (accept) begin
            slot_offset <= dec_offset;
            slot_wen    <= core_wen;
            slot_wdata  <= core_wdata;
            slot_wmask  <= core_wmask;
        end
    end

    // held fields stay put until the target answers
    // core must keep its strobes stable while core_ready is low

endmodule

// File: hw/mmio_device_mux.sv
module mmio_device_mux import mmio_pkg::*; (
    // held request
    input  logic         slot_valid,
    input  mmio_target_t slot_target,
    input  addr_t        slot_offset,
    input  logic         slot_wen,
    input  data_t        slot_wdata,
    input  mask_t        slot_wmask,

    // response back to slot and core
    output logic         rsp_valid,
    output data_t        rsp_data,

    // ram port
    output logic         ram_valid,
    output addr_t        ram_addr,
    output logic         ram_wen,
    output data_t        ram_wdata,
    output mask_t        ram_wmask,
    input  logic         ram_rvalid,
    input  data_t        ram_rdata,

    // rom port
    output logic         rom_valid,
    output addr_t        rom_addr,
    output logic         rom_wen,
    output data_t        rom_wdata,
    output mask_t        rom_wmask,
    input  logic         rom_rvalid,
    input  data_t        rom_rdata,

    // debug window port
    output logic         dbg_valid,
    output addr_t        dbg_addr,
    output logic         dbg_wen,
    output data_t        dbg_wdata,
    output mask_t        dbg_wmask,
    input  logic         dbg_rvalid,
    input  data_t        dbg_rdata,

    // aclint port
    output logic         aclint_valid,
    output addr_t        aclint_addr,
    output logic         aclint_wen,
    output data_t        aclint_wdata,
    output mask_t        aclint_wmask,
    input  logic         aclint_rvalid,
    input  data_t        aclint_rdata
);

    // ==============================
    // request side
    // ==============================

    // one-hot port select, all low when the slot is empty
    assign ram_valid    = slot_valid && (slot_target == target_ram);
    assign rom_valid    = slot_valid && (slot_target == target_rom);
    assign dbg_valid    = slot_valid && (slot_target == target_dbg);
    assign aclint_valid = slot_valid && (slot_target == target_aclint);

    // unselected ports idle at zero
    assign ram_addr  = ram_valid ? slot_offset : '0;
    assign ram_wen   = ram_valid && slot_wen;
    assign ram_wdata = ram_valid ? slot_wdata : '0;
    assign ram_wmask = ram_valid ? slot_wmask : '0;

    assign rom_addr  = rom_valid ? slot_offset : '0;
    assign rom_wen   = rom_valid && slot_wen;
    assign rom_wdata = rom_valid ? slot_wdata : '0;
    assign rom_wmask = rom_valid ? slot_wmask : '0;

    assign dbg_addr  = dbg_valid ? slot_offset : '0;
    assign dbg_wen   = dbg_valid && slot_wen;
    assign dbg_wdata = dbg_valid ? slot_wdata : '0;
    assign dbg_wmask = dbg_valid ? slot_wmask : '0;

    assign aclint_addr  = aclint_valid ? slot_offset : '0;
    assign aclint_wen   = aclint_valid && slot_wen;
    assign aclint_wdata = aclint_valid ? slot_wdata : '0;
    assign aclint_wmask = aclint_valid ? slot_wmask : '0;

    // ==============================
    // response side
    // ==============================
    always_comb begin
        rsp_valid = 1'b0;
        rsp_data  = '0;
        if (slot_valid) begin
            case (slot_target)
                target_ram: begin
                    rsp_valid = ram_rvalid;
                    rsp_data  = ram_rdata;
                end
                target_rom: begin
                    rsp_valid = rom_rvalid;
                    rsp_data  = rom_rdata;
                end
                target_dbg: begin
                    rsp_valid = dbg_rvalid;
                    rsp_data  = dbg_rdata;
                end
                target_aclint: begin
                    rsp_valid = aclint_rvalid;
                    rsp_data  = aclint_rdata;
                end
                // unmapped completes at once, read data zero
                default: begin
                    rsp_valid = 1'b1;
                    rsp_data  = '0;
                end
            endcase
        end
    end

endmodule

// File: hw/mmio_controller.sv
`include "mmio_cfg.svh"

module mmio_controller import mmio_pkg::*; (
    input  logic  clk,
    input  logic  rst,

    // run-time debug window base
    input  addr_t dbg_addr,

    // core side
    input  logic  core_valid,
    input  addr_t core_addr,
    input  logic  core_wen,
    input  data_t core_wdata,
    input  mask_t core_wmask,
    output logic  core_ready,
    output logic  core_rvalid,
    output data_t core_rdata,

    // ram
    output logic  ram_valid,
    output addr_t ram_addr,
    output logic  ram_wen,
    output data_t ram_wdata,
    output mask_t ram_wmask,
    input  logic  ram_rvalid,
    input  data_t ram_rdata,

    // rom
    output logic  rom_valid,
    output addr_t rom_addr,
    output logic  rom_wen,
    output data_t rom_wdata,
    output mask_t rom_wmask,
    input  logic  rom_rvalid,
    input  data_t rom_rdata,

    // debug window
    output logic  dbg_valid,
    output addr_t dbg_addr_out,
    output logic  dbg_wen,
    output data_t dbg_wdata,
    output mask_t dbg_wmask,
    input  logic  dbg_rvalid,
    input  data_t dbg_rdata,

    // aclint
    output logic  aclint_valid,
    output addr_t aclint_addr,
    output logic  aclint_wen,
    output data_t aclint_wdata,
    output mask_t aclint_wmask,
    input  logic  aclint_rvalid,
    input  data_t aclint_rdata
);

    // decode of the live core address
    mmio_target_t dec_target;
    addr_t        dec_offset;

    // held request
    logic         slot_valid;
    mmio_target_t slot_target;
    addr_t        slot_offset;
    logic         slot_wen;
    data_t        slot_wdata;
    mask_t        slot_wmask;

    // completion from the selected target
    logic         rsp_valid;
    data_t        rsp_data;

    // ==============================
    // address decode
    // ==============================
    mmio_decoder u_decoder (
        .addr     (core_addr),
        .dbg_addr (dbg_addr),
        .target   (dec_target),
        .offset   (dec_offset)
    );

    // ==============================
    // single outstanding slot
    // ==============================
    mmio_request_slot u_slot (
        .clk         (clk),
        .rst         (rst),
        .core_valid  (core_valid),
        .core_wen    (core_wen),
        .core_wdata  (core_wdata),
        .core_wmask  (core_wmask),
        .dec_target  (dec_target),
        .dec_offset  (dec_offset),
        .rsp_valid   (rsp_valid),
        .core_ready  (core_ready),
        .slot_valid  (slot_valid),
        .slot_target (slot_target),
        .slot_offset (slot_offset),
        .slot_wen    (slot_wen),
        .slot_wdata  (slot_wdata),
        .slot_wmask  (slot_wmask)
    );

    // ==============================
    // target ports and response
    // ==============================
    mmio_device_mux u_mux (
        .slot_valid    (slot_valid),
        .slot_target   (slot_target),
        .slot_offset   (slot_offset),
        .slot_wen      (slot_wen),
        .slot_wdata    (slot_wdata),
        .slot_wmask    (slot_wmask),
        .rsp_valid     (rsp_valid),
        .rsp_data      (rsp_data),
        .ram_valid     (ram_valid),
        .ram_addr      (ram_addr),
        .ram_wen       (ram_wen),
        .ram_wdata     (ram_wdata),
        .ram_wmask     (ram_wmask),
        .ram_rvalid    (ram_rvalid),
        .ram_rdata     (ram_rdata),
        .rom_valid     (rom_valid),
        .rom_addr      (rom_addr),
        .rom_wen       (rom_wen),
        .rom_wdata     (rom_wdata),
        .rom_wmask     (rom_wmask),
        .rom_rvalid    (rom_rvalid),
        .rom_rdata     (rom_rdata),
        .dbg_valid     (dbg_valid),
        .dbg_addr      (dbg_addr_out),
        .dbg_wen       (dbg_wen),
        .dbg_wdata     (dbg_wdata),
        .dbg_wmask     (dbg_wmask),
        .dbg_rvalid    (dbg_rvalid),
        .dbg_rdata     (dbg_rdata),
        .aclint_valid  (aclint_valid),
        .aclint_addr   (aclint_addr),
        .aclint_wen    (aclint_wen),
        .aclint_wdata  (aclint_wdata),
        .aclint_wmask  (aclint_wmask),
        .aclint_rvalid (aclint_rvalid),
        .aclint_rdata  (aclint_rdata)
    );

    // response goes straight back to the core
    assign core_rvalid = rsp_valid;
    assign core_rdata  = rsp_data;

endmodule

// File: sim/tb_clk_gen.sv
module tb_clk_gen (
    output logic clk,
    output logic rst
);

    timeunit 1ns;
    timeprecision 1ps;

    // 20 ns period
    initial begin
        clk = 1'b0;
        forever begin
            #10 clk = ~clk;
        end
    end

    // active low reset, released after 10 rising edges
    initial begin
        rst = 1'b0;
        repeat (10) @(posedge clk);
        rst <= 1'b1;
    end

endmodule

// File: sim/tb_mmio_devices.sv
module tb_mmio_devices import mmio_pkg::*; (
    input  logic  clk,
    input  logic  rst,

    input  logic  ram_valid,
    input  addr_t ram_addr,
    input  logic  ram_wen,
    input  data_t ram_wdata,
    input  mask_t ram_wmask,
    output logic  ram_rvalid,
    output data_t ram_rdata,

    input  logic  rom_valid,
    input  addr_t rom_addr,
    input  logic  rom_wen,
    input  data_t rom_wdata,
    input  mask_t rom_wmask,
    output logic  rom_rvalid,
    output data_t rom_rdata,

    input  logic  dbg_valid,
    input  addr_t dbg_addr,
    input  logic  dbg_wen,
    input  data_t dbg_wdata,
    input  mask_t dbg_wmask,
    output logic  dbg_rvalid,
    output data_t dbg_rdata,

    input  logic  aclint_valid,
    input  addr_t aclint_addr,
    input  logic  aclint_wen,
    input  data_t aclint_wdata,
    input  mask_t aclint_wmask,
    output logic  aclint_rvalid,
    output data_t aclint_rdata
);

    timeunit 1ns;
    timeprecision 1ps;

    // model index order: ram 0, rom 1, dbg 2, aclint 3
    logic [3:0] v;
    logic [3:0] w;
    addr_t      a [4];
    data_t      wd [4];
    mask_t      wm [4];

    // per model state
    logic [3:0] rv;
    logic [3:0] busy;
    logic [1:0] cnt [4];
    logic [31:0] lfsr;

    // last request seen, read by the testbench top
    addr_t last_addr [4];
    logic  last_wen [4];
    data_t last_wdata [4];
    mask_t last_wmask [4];

    assign v = {aclint_valid, dbg_valid, rom_valid, ram_valid};
    assign w = {aclint_wen, dbg_wen, rom_wen, ram_wen};
    assign a[0] = ram_addr;
    assign a[1] = rom_addr;
    assign a[2] = dbg_addr;
    assign a[3] = aclint_addr;
    assign wd[0] = ram_wdata;
    assign wd[1] = rom_wdata;
    assign wd[2] = dbg_wdata;
    assign wd[3] = aclint_wdata;
    assign wm[0] = ram_wmask;
    assign wm[1] = rom_wmask;
    assign wm[2] = dbg_wmask;
    assign wm[3] = aclint_wmask;

    // galois lfsr, x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    // ==============================
    // delay and response
    // ==============================
    always @(posedge clk or negedge rst) begin
        logic [31:0] s;
        logic [1:0]  d;
        if (!rst) begin
            lfsr <= 32'h6abe_51b8;
            rv   <= '0;
            busy <= '0;
            for (int i = 0; i < 4; i++) begin
                cnt[i] <= '0;
            end
        end else begin
            s = lfsr;
            for (int i = 0; i < 4; i++) begin
                if (rv[i]) begin
                    // one cycle pulse, router drops valid next
                    rv[i]   <= 1'b0;
                    busy[i] <= 1'b0;
                end else if (busy[i]) begin
                    if (cnt[i] == 2'd0) begin
                        rv[i] <= 1'b1;
                    end else begin
                        cnt[i] <= cnt[i] - 2'd1;
                    end
                end else if (v[i]) begin
                    // two lfsr bits give 0 to 3 cycles
                    d[0] = s[0];
                    s = lfsr_next(s);
                    d[1] = s[0];
                    s = lfsr_next(s);
                    busy[i]       <= 1'b1;
                    cnt[i]        <= d;
                    last_addr[i]  <= a[i];
                    last_wen[i]   <= w[i];
                    last_wdata[i] <= wd[i];
                    last_wmask[i] <= wm[i];
                end
            end
            lfsr <= s;
        end
    end

    // read pattern: model index in the top byte, offset below
    assign ram_rvalid    = rv[0];
    assign rom_rvalid    = rv[1];
    assign dbg_rvalid    = rv[2];
    assign aclint_rvalid = rv[3];
    assign ram_rdata    = rv[0] ? {8'd0, ram_addr[55:0]} : '0;
    assign rom_rdata    = rv[1] ? {8'd1, rom_addr[55:0]} : '0;
    assign dbg_rdata    = rv[2] ? {8'd2, dbg_addr[55:0]} : '0;
    assign aclint_rdata = rv[3] ? {8'd3, aclint_addr[55:0]} : '0;

endmodule

// File: sim/tb_mmio_controller.sv
`include "mmio_cfg.svh"

module tb_mmio_controller import mmio_pkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    // requests issued by all tests together
    localparam int n_requests = 27;

    logic  clk;
    logic  rst;
    addr_t dbg_base;

    logic  core_valid;
    addr_t core_addr;
    logic  core_wen;
    data_t core_wdata;
    mask_t core_wmask;
    logic  core_ready;
    logic  core_rvalid;
    data_t core_rdata;

    logic  ram_valid, rom_valid, dbg_valid, aclint_valid;
    addr_t ram_addr, rom_addr, dbg_addr, aclint_addr;
    logic  ram_wen, rom_wen, dbg_wen, aclint_wen;
    data_t ram_wdata, rom_wdata, dbg_wdata, aclint_wdata;
    mask_t ram_wmask, rom_wmask, dbg_wmask, aclint_wmask;
    logic  ram_rvalid, rom_rvalid, dbg_rvalid, aclint_rvalid;
    data_t ram_rdata, rom_rdata, dbg_rdata, aclint_rdata;

    tb_clk_gen u_clk (.clk(clk), .rst(rst));

    mmio_controller u_dut (
        .clk (clk), .rst (rst), .dbg_addr (dbg_base),
        .core_valid (core_valid), .core_addr (core_addr), .core_wen (core_wen),
        .core_wdata (core_wdata), .core_wmask (core_wmask), .core_ready (core_ready),
        .core_rvalid (core_rvalid), .core_rdata (core_rdata),
        .ram_valid (ram_valid), .ram_addr (ram_addr), .ram_wen (ram_wen),
        .ram_wdata (ram_wdata), .ram_wmask (ram_wmask),
        .ram_rvalid (ram_rvalid), .ram_rdata (ram_rdata),
        .rom_valid (rom_valid), .rom_addr (rom_addr), .rom_wen (rom_wen),
        .rom_wdata (rom_wdata), .rom_wmask (rom_wmask),
        .rom_rvalid (rom_rvalid), .rom_rdata (rom_rdata),
        .dbg_valid (dbg_valid), .dbg_addr_out (dbg_addr), .dbg_wen (dbg_wen),
        .dbg_wdata (dbg_wdata), .dbg_wmask (dbg_wmask),
        .dbg_rvalid (dbg_rvalid), .dbg_rdata (dbg_rdata),
        .aclint_valid (aclint_valid), .aclint_addr (aclint_addr),
        .aclint_wen (aclint_wen), .aclint_wdata (aclint_wdata),
        .aclint_wmask (aclint_wmask),
        .aclint_rvalid (aclint_rvalid), .aclint_rdata (aclint_rdata)
    );

    tb_mmio_devices u_devices (.*);

    // ==============================
    // check helpers
    // ==============================
    task automatic stop_run();
        $display("Testbench failed");
        $fatal(1, "stopping at first error");
    endtask

    task automatic check_hex(input string name, input logic [63:0] got, input logic [63:0] exp);
        assert (got === exp) else begin
            $display("ERR %s got 0x%h exp 0x%h", name, got, exp);
            stop_run();
        end
    endtask

    task automatic check_true(input logic cond, input string what);
        assert (cond === 1'b1) else begin
            $display("%s", what);
            stop_run();
        end
    endtask

    // port index order is ram 0, rom 1, dbg 2, aclint 3
    function automatic logic [3:0] valid_vec();
        return {aclint_valid, dbg_valid, rom_valid, ram_valid};
    endfunction

    function automatic addr_t port_addr(input int idx);
        case (idx)
            0: return ram_addr;
            1: return rom_addr;
            2: return dbg_addr;
            default: return aclint_addr;
        endcase
    endfunction

    // wen in the top bit, then wmask, then wdata
    function automatic logic [72:0] port_fields(input int idx);
        case (idx)
            0: return {ram_wen, ram_wmask, ram_wdata};
            1: return {rom_wen, rom_wmask, rom_wdata};
            2: return {dbg_wen, dbg_wmask, dbg_wdata};
            default: return {aclint_wen, aclint_wmask, aclint_wdata};
        endcase
    endfunction

    // expected read word of a model
    function automatic data_t pattern(input int idx, input addr_t off);
        return {idx[7:0], off[55:0]};
    endfunction

    // checks the routed port each cycle until core_rvalid
    task automatic wait_done(input int idx, input addr_t off, input logic wen,
                             input data_t wdata, input mask_t wmask,
                             output int cycles, output data_t rd);
        logic [3:0]  exp_v;
        logic [72:0] fields;
        exp_v = (idx < 0) ? 4'b0000 : (4'b0001 << idx);
        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
            check_true(!core_ready, "core_ready high while a request is outstanding");
            check_hex("target valid", valid_vec(), exp_v);
            if (idx >= 0) begin
                fields = port_fields(idx);
                check_hex("target addr", port_addr(idx), off);
                check_hex("target wen", fields[72], wen);
                check_hex("target wmask", fields[71:64], wmask);
                check_hex("target wdata", fields[63:0], wdata);
            end
        end while (!core_rvalid);
        rd = core_rdata;
    endtask

    // one full access with idx -1 for unmapped
    task automatic do_access(input addr_t addr, input logic wen, input data_t wdata,
                             input mask_t wmask, input int idx, input addr_t off);
        int    cycles;
        data_t rd;
        @(posedge clk);
        core_valid <= 1'b1;
        core_addr  <= addr;
        core_wen   <= wen;
        core_wdata <= wdata;
        core_wmask <= wmask;
        @(negedge clk);
        check_true(core_ready, "core_ready low with nothing outstanding");
        @(posedge clk);
        core_valid <= 1'b0;
        wait_done(idx, off, wen, wdata, wmask, cycles, rd);
        if (idx < 0) begin
            check_hex("unmapped latency", cycles, 1);
            check_hex("core_rdata", rd, 0);
        end else begin
            if (!wen) begin
                check_hex("core_rdata", rd, pattern(idx, off));
            end
            // what the model itself captured
            check_hex("model addr", u_devices.last_addr[idx], off);
            check_hex("model wen", u_devices.last_wen[idx], wen);
            check_hex("model wdata", u_devices.last_wdata[idx], wdata);
            check_hex("model wmask", u_devices.last_wmask[idx], wmask);
        end
        @(posedge clk);
        @(negedge clk);
        check_true(core_ready, "core_ready not high in the cycle after completion");
    endtask

    // ==============================
    // tests
    // ==============================
    task automatic test_reset_state();
        wait (rst === 1'b1);
        @(negedge clk);
        check_hex("core_ready", core_ready, 1);
        check_hex("core_rvalid", core_rvalid, 0);
        check_hex("target valid", valid_vec(), 0);
    endtask

    task automatic test_read_routing();
        do_access(64'h8000_1238, 1'b0, '0, '0, 0, 64'h1238);
        do_access(64'h0000_1ff8, 1'b0, '0, '0, 1, 64'h0ff8);
        do_access(64'h0200_bff8, 1'b0, '0, '0, 3, 64'hbff8);
    endtask

    task automatic test_dbg_priority();
        // debug base sits inside ram
        @(posedge clk);
        dbg_base <= 64'h8000_4000;
        do_access(64'h8000_4000, 1'b0, '0, '0, 2, 64'h0);
        do_access(64'h8000_4007, 1'b0, '0, '0, 2, 64'h7);
        do_access(64'h8000_4008, 1'b0, '0, '0, 0, 64'h4008);
    endtask

    task automatic test_writes();
        do_access(64'h8000_0040, 1'b1, 64'hdead_beef_0123_4567, 8'h0f, 0, 64'h40);
        do_access(64'h0000_1010, 1'b1, 64'h1111_2222_3333_4444, 8'hff, 1, 64'h10);
        do_access(64'h8000_4003, 1'b1, 64'h5a5a_a5a5_0f0f_f0f0, 8'h81, 2, 64'h3);
        do_access(64'h0200_4000, 1'b1, 64'hcafe_f00d_8765_4321, 8'hf0, 3, 64'h4000);
    endtask

    // second request held on the bus while the first is in flight
    task automatic test_outstanding();
        addr_t a_addr, b_addr, a_off, b_off;
        int    a_idx, b_idx, cycles;
        data_t rd;
        for (int i = 0; i < 8; i++) begin
            a_off = 64'h100 + i * 8;
            b_off = i * 8;
            a_addr = `MMIO_RAM_BEGIN + a_off;
            b_addr = `MMIO_ROM_BEGIN + b_off;
            a_idx = 0;
            b_idx = 1;
            if (i % 2) begin
                {a_addr, b_addr} = {b_addr, a_addr};
                {a_off, b_off} = {b_off, a_off};
                a_idx = 1;
                b_idx = 0;
            end
            @(posedge clk);
            core_valid <= 1'b1;
            core_addr  <= a_addr;
            core_wen   <= 1'b0;
            @(negedge clk);
            check_true(core_ready, "core_ready low before the first request");
            @(posedge clk);
            core_addr <= b_addr;
            wait_done(a_idx, a_off, 1'b0, core_wdata, core_wmask, cycles, rd);
            check_hex("core_rdata", rd, pattern(a_idx, a_off));
            @(posedge clk);
            @(negedge clk);
            check_true(core_ready, "held request taken before the first one completed");
            check_hex("target valid", valid_vec(), 0);
            @(posedge clk);
            core_valid <= 1'b0;
            wait_done(b_idx, b_off, 1'b0, core_wdata, core_wmask, cycles, rd);
            check_hex("core_rdata", rd, pattern(b_idx, b_off));
            @(posedge clk);
            @(negedge clk);
            check_true(core_ready, "core_ready not high after the second request");
        end
    endtask

    task automatic test_unmapped();
        // gap between rom and aclint
        do_access(64'h0100_0000, 1'b0, '0, '0, -1, '0);
    endtask

    // ==============================
    // run
    // ==============================
    initial begin
        dbg_base   = 64'h8000_4000;
        core_valid = 1'b0;
        core_addr  = '0;
        core_wen   = 1'b0;
        core_wdata = '0;
        core_wmask = '0;
    end

    initial begin
        test_reset_state();
        test_read_routing();
        test_dbg_priority();
        test_writes();
        test_outstanding();
        test_unmapped();
        $display("Testbench passed");
        $finish;
    end

    // watchdog sized from the request count
    initial begin
        repeat (n_requests * 8 + 100) @(posedge clk);
        $display("timeout, the tests did not finish in time");
        $display("Testbench failed");
        $fatal(1, "watchdog expired");
    end

endmodule

// File: flist.f
+incdir+include
hw/mmio_pkg.sv
hw/mmio_decoder.sv
hw/mmio_request_slot.sv
hw/mmio_device_mux.sv
hw/mmio_controller.sv
sim/tb_clk_gen.sv
sim/tb_mmio_devices.sv
sim/tb_mmio_controller.sv

// File: Bender.yml
package:
  name: mmio_router

sources:
  - include_dirs:
      - include
    files:
      - hw/mmio_pkg.sv
      - hw/mmio_decoder.sv
      - hw/mmio_request_slot.sv
      - hw/mmio_device_mux.sv
      - hw/mmio_controller.sv
      - target: simulation
        files:
          - sim/tb_clk_gen.sv
          - sim/tb_mmio_devices.sv
          - sim/tb_mmio_controller.sv
